//--- hdl/fe_defs.svh
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// Converter and bus widths for the front end

// Parallel ADC bus and receive sample width
`define FE_ADC_W 14

// Interleaved I/Q bus to and from the RF transceiver
`define FE_LMS_W 12

// Parallel DAC channel, also the core-side transmit word
`define FE_DAC_W 16

// Guard against a transceiver bus wider than a receive sample
`define FE_PAD_W (`FE_ADC_W - `FE_LMS_W)

`endif

//--- hdl/fe_pkg.sv
package fe_pkg;

   // Front-end variant, strapped on the board
   // Only changes while the design is held in reset
   typedef enum logic
   {
      FE_PARALLEL = 1'b0,    // Two parallel ADC buses, two DAC channels
      FE_IQ_MUX   = 1'b1     // One bus, I and Q words in turn
   } fe_mode_e;

   // Half of an I/Q pair
   // Matches the level of the transceiver select pin
   typedef enum logic
   {
      PH_I = 1'b0,           // Select low, I word
      PH_Q = 1'b1            // Select high, Q word
   } iq_phase_e;

endpackage

//--- hdl/adc_capture.sv
`include "fe_defs.svh"

module adc_capture
(
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  fe_pkg::fe_mode_e       mode_i,        // Static strap
   input  logic [`FE_ADC_W-1:0]   adc_a_i,       // ADC A pins, routed inverted
   input  logic [`FE_ADC_W-1:0]   adc_b_i,       // ADC B pins
   input  logic [`FE_LMS_W-1:0]   lms_rx_i,      // Interleaved I/Q word
   input  logic                   lms_iqsel_i,   // Low for I, high for Q
   output logic [`FE_ADC_W-1:0]   cap_a_o,       // A channel or interleaved word
   output logic [`FE_ADC_W-1:0]   cap_b_o,       // B channel, zero in I/Q mode
   output logic                   cap_iqsel_o,   // Select bit of the captured word
   output logic                   cap_load_o     // A word was captured
);

   import fe_pkg::*;

   localparam int PAD_W = `FE_PAD_W;             // Zero bits above a 12-bit word

   logic [`FE_ADC_W-1:0] lms_wide;               // Interleaved word widened

   // Transceiver data sits in the low bits
   assign lms_wide = {{PAD_W{1'b0}}, lms_rx_i};

   // Data registers
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cap_a_o <= '0;
         cap_b_o <= '0;
      end
      else if (mode_i == FE_PARALLEL)
      begin
         cap_a_o <= ~adc_a_i;                    // Undo board inversion of A
         cap_b_o <= adc_b_i;
      end
      else
      begin
         cap_a_o <= lms_wide;                    // I or Q, per select bit
         cap_b_o <= '0;                          // B bus not populated
      end
   end

   // Select bit and load marker
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cap_iqsel_o <= 1'b0;
         cap_load_o  <= 1'b0;                    // Nothing captured yet
      end
      else
      begin
         cap_load_o <= 1'b1;                     // Converters run every cycle
         if (mode_i == FE_PARALLEL)
         begin
            cap_iqsel_o <= 1'b0;                 // Both halves arrive together
         end
         else
         begin
            cap_iqsel_o <= lms_iqsel_i;          // Keep word alignment for stage 2
         end
      end
   end

   // The strap may only move while reset is held
   a_mode_stable : assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      $stable(mode_i)
   );

endmodule

//--- hdl/iq_pair_align.sv
`include "fe_defs.svh"

module iq_pair_align
(
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  fe_pkg::fe_mode_e       mode_i,        // Static strap
   input  logic [`FE_ADC_W-1:0]   cap_a_i,       // Captured A or interleaved word
   input  logic [`FE_ADC_W-1:0]   cap_b_i,       // Captured B
   input  logic                   cap_iqsel_i,   // Low for I, high for Q
   input  logic                   cap_load_i,    // Captured word present
   output logic [`FE_ADC_W-1:0]   rx_i_o,        // I of the sample
   output logic [`FE_ADC_W-1:0]   rx_q_o,        // Q of the sample
   output logic                   rx_valid_o     // Sample complete this cycle
);

   import fe_pkg::*;

   iq_phase_e            ph;                     // PH_Q while an I is held
   logic [`FE_ADC_W-1:0] hold_i;                 // Pending I word
   logic                 iq_mode;                // Interleaved front end
   logic                 i_hit;                  // I word arrives
   logic                 pair_hit;               // Q directly after an I

   assign iq_mode  = (mode_i == FE_IQ_MUX);
   assign i_hit    = iq_mode && cap_load_i && !cap_iqsel_i;
   assign pair_hit = iq_mode && cap_load_i && cap_iqsel_i && (ph == PH_Q);

   // Sample data
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         rx_i_o <= '0;
         rx_q_o <= '0;
         hold_i <= '0;
      end
      else if (!iq_mode)
      begin
         rx_i_o <= cap_a_i;                      // Both channels each cycle
         rx_q_o <= cap_b_i;
      end
      else
      begin
         if (i_hit)
         begin
            hold_i <= cap_a_i;                   // A repeated I overwrites
         end
         if (pair_hit)
         begin
            rx_i_o <= hold_i;
            rx_q_o <= cap_a_i;
         end
      end
   end

   // Pairing FSM and valid
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ph         <= PH_I;
         rx_valid_o <= 1'b0;
      end
      else if (!iq_mode)
      begin
         ph         <= PH_I;                     // Unused in parallel mode
         rx_valid_o <= cap_load_i;
      end
      else
      begin
         rx_valid_o <= pair_hit;                 // Orphan Q gives nothing
         ph         <= i_hit ? PH_Q : PH_I;      // Q must follow at once
      end
   end

   // A pair takes two words, so valid cannot repeat back to back
   a_valid_spaced : assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      (mode_i == FE_IQ_MUX && rx_valid_o) |=> !rx_valid_o
   );

endmodule

//--- hdl/dac_format.sv
`include "fe_defs.svh"

module dac_format
(
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  fe_pkg::fe_mode_e       mode_i,        // Static strap
   input  logic [`FE_DAC_W-1:0]   tx_a_i,        // Core I word
   input  logic [`FE_DAC_W-1:0]   tx_b_i,        // Core Q word
   output logic [`FE_DAC_W-1:0]   dac_a_o,       // DAC A pins, routed inverted
   output logic [`FE_DAC_W-1:0]   dac_b_o,       // DAC B pins
   output logic [`FE_LMS_W-1:0]   lms_tx_o,      // Interleaved I/Q word
   output logic                   lms_iqsel_o    // Low for I, high for Q
);

   import fe_pkg::*;

   iq_phase_e            ph;                     // Half sent at this edge
   iq_phase_e            ph_nxt;
   logic [`FE_LMS_W-1:0] tx_a_lo;                // I truncated to the bus
   logic [`FE_LMS_W-1:0] tx_b_lo;                // Q truncated to the bus

   assign tx_a_lo = tx_a_i[`FE_LMS_W-1:0];
   assign tx_b_lo = tx_b_i[`FE_LMS_W-1:0];
   assign ph_nxt  = (ph == PH_I) ? PH_Q : PH_I;

   // Output registers, rising edge
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ph          <= PH_I;                    // First edge sends I
         dac_a_o     <= '0;
         dac_b_o     <= '0;
         lms_tx_o    <= '0;
         lms_iqsel_o <= 1'b0;
      end
      else if (mode_i == FE_PARALLEL)
      begin
         ph          <= PH_I;
         dac_a_o     <= ~tx_b_i;                 // Channels swapped on the board
         dac_b_o     <= tx_a_i;                  // and A is inverted
         lms_tx_o    <= '0;                      // Transceiver bus idle
         lms_iqsel_o <= 1'b0;
      end
      else
      begin
         ph      <= ph_nxt;
         dac_a_o <= '0;                          // Parallel DAC not fitted
         dac_b_o <= '0;
         if (ph == PH_I)
         begin
            lms_tx_o    <= tx_a_lo;
            lms_iqsel_o <= 1'b0;
         end
         else
         begin
            lms_tx_o    <= tx_b_lo;
            lms_iqsel_o <= 1'b1;
         end
      end
   end

   // Once a Q has gone out, the select keeps alternating I, Q
   a_iqsel_toggle : assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      (mode_i == FE_IQ_MUX && lms_iqsel_o) |=> !lms_iqsel_o ##1 lms_iqsel_o
   );

endmodule

//--- hdl/fe_top.sv
`include "fe_defs.svh"

module fe_top
(
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  fe_pkg::fe_mode_e       mode_i,          // Front-end strap
   // Receive pins
   input  logic [`FE_ADC_W-1:0]   adc_a_i,
   input  logic [`FE_ADC_W-1:0]   adc_b_i,
   input  logic [`FE_LMS_W-1:0]   lms_rx_i,
   input  logic                   lms_rx_iqsel_i,
   // Transmit words from the core
   input  logic [`FE_DAC_W-1:0]   tx_a_i,
   input  logic [`FE_DAC_W-1:0]   tx_b_i,
   // Receive samples to the core
   output logic [`FE_ADC_W-1:0]   rx_i_o,
   output logic [`FE_ADC_W-1:0]   rx_q_o,
   output logic                   rx_valid_o,
   // Transmit pins
   output logic [`FE_DAC_W-1:0]   dac_a_o,
   output logic [`FE_DAC_W-1:0]   dac_b_o,
   output logic [`FE_LMS_W-1:0]   lms_tx_o,
   output logic                   lms_tx_iqsel_o
);

   logic [`FE_ADC_W-1:0] cap_a;                    // Stage 1 to stage 2
   logic [`FE_ADC_W-1:0] cap_b;
   logic                 cap_iqsel;
   logic                 cap_load;

   // Receive stage 1, pin capture
   adc_capture u_adc_capture
   (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .mode_i      (mode_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .lms_rx_i    (lms_rx_i),
      .lms_iqsel_i (lms_rx_iqsel_i),
      .cap_a_o     (cap_a),
      .cap_b_o     (cap_b),
      .cap_iqsel_o (cap_iqsel),
      .cap_load_o  (cap_load)
   );

   // Receive stage 2, I/Q pairing
   iq_pair_align u_iq_pair_align
   (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .mode_i      (mode_i),
      .cap_a_i     (cap_a),
      .cap_b_i     (cap_b),
      .cap_iqsel_i (cap_iqsel),
      .cap_load_i  (cap_load),
      .rx_i_o      (rx_i_o),
      .rx_q_o      (rx_q_o),
      .rx_valid_o  (rx_valid_o)
   );

   // Transmit formatting
   dac_format u_dac_format
   (
      .dsp_clk     (dsp_clk),
      .arst_n_i    (arst_n_i),
      .mode_i      (mode_i),
      .tx_a_i      (tx_a_i),
      .tx_b_i      (tx_b_i),
      .dac_a_o     (dac_a_o),
      .dac_b_o     (dac_b_o),
      .lms_tx_o    (lms_tx_o),
      .lms_iqsel_o (lms_tx_iqsel_o)
   );

endmodule

//--- testbench/tb_fe_top.sv
`include "fe_defs.svh"

module tb_fe_top;

   import fe_pkg::*;

   localparam int PHASE_CYC   = 200;             // Cycles per mode phase
   localparam int RST_CYC     = 3;               // Reset hold in cycles
   localparam int TIMEOUT_CYC = 3 * PHASE_CYC;   // Two phases, resets, about half again
   localparam int PAD_W       = `FE_ADC_W - `FE_LMS_W;

   logic                 dsp_clk;
   logic                 arst_n_i;
   fe_mode_e             mode_i;                 // Strap, moved only in reset
   logic [`FE_ADC_W-1:0] adc_a_i;
   logic [`FE_ADC_W-1:0] adc_b_i;
   logic [`FE_LMS_W-1:0] lms_rx_i;
   logic                 lms_rx_iqsel_i;
   logic [`FE_DAC_W-1:0] tx_a_i;
   logic [`FE_DAC_W-1:0] tx_b_i;

   logic [`FE_ADC_W-1:0] rx_i_o;
   logic [`FE_ADC_W-1:0] rx_q_o;
   logic                 rx_valid_o;
   logic [`FE_DAC_W-1:0] dac_a_o;
   logic [`FE_DAC_W-1:0] dac_b_o;
   logic [`FE_LMS_W-1:0] lms_tx_o;
   logic                 lms_tx_iqsel_o;

   // Input history, h1 is the value sampled at the previous edge
   logic [`FE_ADC_W-1:0] adc_a_h1;
   logic [`FE_ADC_W-1:0] adc_a_h2;
   logic [`FE_ADC_W-1:0] adc_b_h1;
   logic [`FE_ADC_W-1:0] adc_b_h2;
   logic [`FE_LMS_W-1:0] lms_h1;
   logic [`FE_LMS_W-1:0] lms_h2;
   logic [`FE_LMS_W-1:0] lms_h3;
   logic                 sel_h1;
   logic                 sel_h2;
   logic                 sel_h3;
   logic [`FE_DAC_W-1:0] tx_a_h1;
   logic [`FE_DAC_W-1:0] tx_b_h1;

   int                   run_cnt;                // Data edges since reset release
   int                   cyc_cnt = 0;            // Watchdog
   int                   n_pair;                 // Stimulus case counters
   int                   n_orphan;
   int                   n_double;

   logic                 odd_edge;               // Last edge was an I-phase edge
   logic                 pair_due;               // Q directly after I, two edges ago
   logic [`FE_LMS_W-1:0] exp_lms_tx;

   fe_top u_fe_top
   (
      .dsp_clk        (dsp_clk),
      .arst_n_i       (arst_n_i),
      .mode_i         (mode_i),
      .adc_a_i        (adc_a_i),
      .adc_b_i        (adc_b_i),
      .lms_rx_i       (lms_rx_i),
      .lms_rx_iqsel_i (lms_rx_iqsel_i),
      .tx_a_i         (tx_a_i),
      .tx_b_i         (tx_b_i),
      .rx_i_o         (rx_i_o),
      .rx_q_o         (rx_q_o),
      .rx_valid_o     (rx_valid_o),
      .dac_a_o        (dac_a_o),
      .dac_b_o        (dac_b_o),
      .lms_tx_o       (lms_tx_o),
      .lms_tx_iqsel_o (lms_tx_iqsel_o)
   );

   always #20 dsp_clk = ~dsp_clk;                // Period 40

   // Print the cause, then the verdict, then stop
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   // 12-bit transceiver word into a 14-bit sample
   function automatic logic [`FE_ADC_W-1:0] widen_rx(input logic [`FE_LMS_W-1:0] w);
      return {{PAD_W{1'b0}}, w};
   endfunction

   // One rising edge of fresh random pins
   task automatic drive_cycle(input logic sel);
      logic [31:0] r_adc;
      logic [31:0] r_tx;
      logic [31:0] r_lms;
      r_adc = $urandom;
      r_tx  = $urandom;
      r_lms = $urandom;
      @(posedge dsp_clk);
      adc_a_i        <= r_adc[`FE_ADC_W-1:0];
      adc_b_i        <= r_adc[16 +: `FE_ADC_W];
      tx_a_i         <= r_tx[15:0];
      tx_b_i         <= r_tx[31:16];
      lms_rx_i       <= r_lms[`FE_LMS_W-1:0];
      lms_rx_iqsel_i <= sel;                     // Ignored in parallel mode
   endtask

   task automatic parallel_phase();
      logic [31:0] r_sel;
      repeat (PHASE_CYC)
      begin
         r_sel = $urandom;
         drive_cycle(r_sel[0]);
      end
   endtask

   // Mostly I,Q pairs, some lone Q words and some I,I,Q runs
   task automatic interleaved_phase();
      int cyc;
      int pick;
      cyc = 0;
      while (cyc < PHASE_CYC)
      begin
         pick = $urandom_range(7, 0);
         if (pick == 0)
         begin
            drive_cycle(PH_Q);                   // Follows a Q, so orphan
            cyc      = cyc + 1;
            n_orphan = n_orphan + 1;
         end
         else if (pick == 1)
         begin
            drive_cycle(PH_I);
            drive_cycle(PH_I);                   // Replaces the first I
            drive_cycle(PH_Q);
            cyc      = cyc + 3;
            n_double = n_double + 1;
         end
         else
         begin
            drive_cycle(PH_I);
            drive_cycle(PH_Q);
            cyc    = cyc + 2;
            n_pair = n_pair + 1;
         end
      end
   endtask

   task automatic reset_to_mode(input fe_mode_e new_mode);
      @(posedge dsp_clk);
      arst_n_i <= 1'b0;
      @(posedge dsp_clk);
      mode_i <= new_mode;                        // Strap moves inside reset
      repeat (RST_CYC - 1) @(posedge dsp_clk);
      arst_n_i <= 1'b1;
   endtask

   always @(posedge dsp_clk)
   begin
      adc_a_h1 <= adc_a_i;
      adc_a_h2 <= adc_a_h1;
      adc_b_h1 <= adc_b_i;
      adc_b_h2 <= adc_b_h1;
      lms_h1   <= lms_rx_i;
      lms_h2   <= lms_h1;
      lms_h3   <= lms_h2;
      sel_h1   <= lms_rx_iqsel_i;
      sel_h2   <= sel_h1;
      sel_h3   <= sel_h2;
      tx_a_h1  <= tx_a_i;
      tx_b_h1  <= tx_b_i;
   end

   // Counts edges taken with reset released
   always @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_cnt <= 0;
      end
      else
      begin
         run_cnt <= run_cnt + 1;
      end
   end

   assign odd_edge   = run_cnt[0];               // First data edge sends I
   assign pair_due   = (run_cnt >= 3) && sel_h2 && !sel_h3;
   assign exp_lms_tx = odd_edge ? tx_a_h1[`FE_LMS_W-1:0] : tx_b_h1[`FE_LMS_W-1:0];

   always @(posedge dsp_clk)
   begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= TIMEOUT_CYC)
      begin
         abort_run($sformatf("Timeout: run still going after %0d clock cycles",
                             TIMEOUT_CYC));
      end
   end

   initial
   begin
      void'($urandom(32'ha963_d0de));
      dsp_clk        = 1'b0;
      arst_n_i       = 1'b0;
      mode_i         = FE_PARALLEL;
      adc_a_i        = '0;
      adc_b_i        = '0;
      lms_rx_i       = '0;
      lms_rx_iqsel_i = 1'b0;
      tx_a_i         = '0;
      tx_b_i         = '0;
      n_pair         = 0;
      n_orphan       = 0;
      n_double       = 0;
      repeat (RST_CYC) @(posedge dsp_clk);
      arst_n_i <= 1'b1;
      parallel_phase();
      reset_to_mode(FE_IQ_MUX);
      interleaved_phase();
      repeat (4) @(posedge dsp_clk);             // Let the last pair come out
      if (n_pair == 0 || n_orphan == 0 || n_double == 0)
      begin
         abort_run("Stimulus never produced one of: I/Q pair, orphan Q, doubled I");
      end
      else
      begin
         $display("All checks passed");
         $finish;
      end
   end

   // Reset values seen at the first edge after release
   a_reset_quiet : assert property (
      @(posedge dsp_clk) $rose(arst_n_i)
         |-> (!rx_valid_o && dac_a_o == '0 && dac_b_o == '0
              && lms_tx_o == '0 && !lms_tx_iqsel_o)
   ) else abort_run($sformatf("[FAIL] %0t: outputs not zero after reset", $time));

   a_par_rx_valid : assert property (
      @(posedge dsp_clk) (mode_i == FE_PARALLEL && arst_n_i)
         |-> (rx_valid_o == (run_cnt >= 2))
   ) else abort_run($sformatf("[FAIL] %0t: parallel rx_valid_o wrong", $time));

   // Two-cycle latency, A bus arrives inverted
   a_par_rx_data : assert property (
      @(posedge dsp_clk) (mode_i == FE_PARALLEL && arst_n_i && run_cnt >= 2)
         |-> (rx_i_o == ~adc_a_h2 && rx_q_o == adc_b_h2)
   ) else abort_run($sformatf("[FAIL] %0t: parallel rx sample differs from A/B bus",
                              $time));

   // Swapped channels, DAC A inverted
   a_par_tx : assert property (
      @(posedge dsp_clk) (mode_i == FE_PARALLEL && arst_n_i && run_cnt >= 1)
         |-> (dac_a_o == ~tx_b_h1 && dac_b_o == tx_a_h1
              && lms_tx_o == '0 && !lms_tx_iqsel_o)
   ) else abort_run($sformatf("[FAIL] %0t: parallel DAC words wrong", $time));

   a_iq_rx_valid : assert property (
      @(posedge dsp_clk) (mode_i == FE_IQ_MUX && arst_n_i)
         |-> (rx_valid_o == pair_due)
   ) else abort_run($sformatf("[FAIL] %0t: interleaved rx_valid_o wrong", $time));

   // I from the edge before the Q, both zero-extended
   a_iq_rx_data : assert property (
      @(posedge dsp_clk) (mode_i == FE_IQ_MUX && arst_n_i && pair_due)
         |-> (rx_i_o == widen_rx(lms_h3) && rx_q_o == widen_rx(lms_h2))
   ) else abort_run($sformatf("[FAIL] %0t: interleaved rx pair holds wrong words",
                              $time));

   a_iq_tx : assert property (
      @(posedge dsp_clk) (mode_i == FE_IQ_MUX && arst_n_i && run_cnt >= 1)
         |-> (lms_tx_iqsel_o == !odd_edge && lms_tx_o == exp_lms_tx
              && dac_a_o == '0 && dac_b_o == '0)
   ) else abort_run($sformatf("[FAIL] %0t: interleaved tx word or select wrong",
                              $time));

endmodule

//--- all.f
+incdir+hdl
hdl/fe_pkg.sv
hdl/adc_capture.sv
hdl/iq_pair_align.sv
hdl/dac_format.sv
hdl/fe_top.sv
testbench/tb_fe_top.sv

//--- Bender.yml
package:
  name: fe_top

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fe_pkg.sv
      - hdl/adc_capture.sv
      - hdl/iq_pair_align.sv
      - hdl/dac_format.sv
      - hdl/fe_top.sv
      - target: simulation
        files:
          - testbench/tb_fe_top.sv
